// File: cpu_stimulus.txt
# P lines give addr and word, W lines give reg, value and compare mask
# The E line gives the final pc and all fields are hex
P 00 A134  # LLB r1 34
P 01 B112  # LHB r1 12
P 02 A2CD  # LLB r2 cd
P 03 B2AB  # LHB r2 ab
P 04 0312  # ADD r3 r1 r2
P 05 1431  # SUB r4 r3 r1
P 06 2542  # XOR r5 r4 r2
P 07 0654  # ADD r6 r5 r4
P 08 1766  # SUB r7 r6 r6 sets Z
P 09 C002  # B NE not taken
P 0A A85A  # LLB r8 5a
P 0B B80F  # LHB r8 0f
P 0C 1981  # SUB r9 r8 r1 sets N
P 0D C602  # B LT taken to 10
P 0E AAEE  # squashed
P 0F 0999  # squashed
P 10 0A98  # ADD r10 r9 r8
P 11 ABFF  # LLB r11 ff
P 12 BB7F  # LHB r11 7f
P 13 0CBB  # ADD r12 r11 r11 sets V
P 14 CC03  # B OV taken to 18
P 15 2CCC  # squashed
P 16 AD11  # squashed
P 17 AD22  # never fetched
P 18 1DCB  # SUB r13 r12 r11
P 19 7000  # no-op opcode
P 1A F000  # HLT
P 1B 0E11  # past HLT
W 1 0034 00FF
W 1 1234 FFFF
W 2 00CD 00FF
W 2 ABCD FFFF
W 3 BE01 FFFF
W 4 ABCD FFFF
W 5 0000 FFFF
W 6 ABCD FFFF
W 7 0000 FFFF
W 8 005A 00FF
W 8 0F5A FFFF
W 9 FD26 FFFF
W A 0C80 FFFF
W B 00FF 00FF
W B 7FFF FFFF
W C FFFE FFFF
W D 7FFF FFFF
E 001B

// File: project.f
cpuPkg.sv
cpuIfs.sv
fetch.sv
decode.sv
execute.sv
result.sv
cpu.sv
cpu_props.sv
cpu_tb.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - cpuPkg.sv
  - cpuIfs.sv
  - fetch.sv
  - decode.sv
  - execute.sv
  - result.sv
  - cpu.sv
  - target: test
    files:
      - cpu_props.sv
      - cpu_tb.sv

// File: cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpuPkg::*; ();

	localparam int ClkPeriod = 4;
	localparam int ProgAddrWidth = 8;
	// Watchdog margin over the program length
	localparam int ExtraCycles = 20;
	// Cycles watched after hlt for stray write-backs
	localparam int DrainCycles = 4;

	logic clk;
	logic reset;
	logic progWrite;
	logic [ProgAddrWidth-1:0] progAddr;
	logic [WordWidth-1:0] progData;
	logic [WordWidth-1:0] pc;
	logic hlt;
	logic wbValid;
	logic [RegAddrWidth-1:0] wbReg;
	logic [WordWidth-1:0] wbData;

	// Program image
	logic [WordWidth-1:0] progAddrQ [$];
	logic [WordWidth-1:0] progWordQ [$];
	// Expected write-back stream, in order
	logic [RegAddrWidth-1:0] expRegQ [$];
	logic [WordWidth-1:0] expDataQ [$];
	logic [WordWidth-1:0] expMaskQ [$];
	logic [WordWidth-1:0] expectedPc;
	logic released;
	int beatCount;

	cpu #(.ProgAddrWidth(ProgAddrWidth)) DUT (.clk(clk), .reset(reset),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.pc(pc), .hlt(hlt), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail %0t: %s expected %h got %h", $time, what, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// Tag letter first, '#' starts a comment up to end of line
	task automatic readStimulus();
		int fd;
		int count;
		logic [7:0] tag;
		logic [WordWidth-1:0] fieldA;
		logic [WordWidth-1:0] fieldB;
		logic [WordWidth-1:0] fieldC;
		logic [8*100-1:0] restOfLine;
		bit done;
		bit badLine;
		bit pcSeen;
		fd = $fopen("cpu_stimulus.txt", "r");
		if (fd == 0) begin
			abortRun("cannot open cpu_stimulus.txt");
		end else begin
			done = 1'b0;
			badLine = 1'b0;
			pcSeen = 1'b0;
			while (!done) begin
				count = $fscanf(fd, " %c", tag);
				if (count != 1) begin
					done = 1'b1;
				end else if (tag == "#") begin
					count = $fgets(restOfLine, fd);
				end else if (tag == "P") begin
					count = $fscanf(fd, "%h %h", fieldA, fieldB);
					badLine = (count != 2);
					progAddrQ.push_back(fieldA);
					progWordQ.push_back(fieldB);
				end else if (tag == "W") begin
					count = $fscanf(fd, "%h %h %h", fieldA, fieldB, fieldC);
					badLine = (count != 3);
					expRegQ.push_back(fieldA[RegAddrWidth-1:0]);
					expDataQ.push_back(fieldB);
					expMaskQ.push_back(fieldC);
				end else if (tag == "E") begin
					count = $fscanf(fd, "%h", fieldA);
					badLine = (count != 1);
					expectedPc = fieldA;
					pcSeen = 1'b1;
				end else begin
					badLine = 1'b1;
				end
				if (badLine) begin
					done = 1'b1;
				end
			end
			$fclose(fd);
			if (badLine) begin
				abortRun("malformed line in cpu_stimulus.txt");
			end else if (!pcSeen) begin
				abortRun("cpu_stimulus.txt has no final pc line");
			end
		end
	endtask

	initial begin
		int unsigned idleCycles;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		released = 1'b0;
		beatCount = 0;
		// Seeded once, only sets the gap between load and release
		idleCycles = 1 + ($urandom(32'h6ae919c6) % 4);
		readStimulus();
		repeat (2) @(posedge clk);
		// Load port, one word per cycle while reset holds
		foreach (progAddrQ[i]) begin
			@(posedge clk);
			#1;
			progWrite = 1'b1;
			progAddr = progAddrQ[i][ProgAddrWidth-1:0];
			progData = progWordQ[i];
		end
		@(posedge clk);
		#1;
		progWrite = 1'b0;
		repeat (idleCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		released = 1'b1;
		wait (hlt === 1'b1);
		// Stay a few cycles so a late write-back gets caught
		repeat (DrainCycles) @(posedge clk);
		#1;
		checkValue(pc, expectedPc, "final pc");
		checkValue(expRegQ.size(), 0, "write-backs still expected");
		$display("test passed");
		$finish;
	end

	// Write-back beats sampled mid-cycle, away from the edge
	always @(negedge clk) begin
		logic [RegAddrWidth-1:0] expReg;
		logic [WordWidth-1:0] expData;
		logic [WordWidth-1:0] expMask;
		if (released && wbValid === 1'b1) begin
			if (expRegQ.size() == 0) begin
				abortRun("write-back seen after the expected stream ended");
			end else begin
				expReg = expRegQ.pop_front();
				expData = expDataQ.pop_front();
				expMask = expMaskQ.pop_front();
				checkValue(wbReg, expReg, $sformatf("beat %0d register", beatCount));
				// Mask hides bytes never written since power-up
				checkValue(wbData & expMask, expData & expMask,
					$sformatf("beat %0d data", beatCount));
				beatCount = beatCount + 1;
			end
		end
	end

	// Watchdog, armed at release
	initial begin
		wait (released);
		#((progAddrQ.size() + ExtraCycles) * ClkPeriod);
		$display("Timeout, the core never halted within %0d cycles",
			progAddrQ.size() + ExtraCycles);
		$display("test failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props import cpuPkg::*; (
	input logic clk,
	input logic reset,
	input logic [WordWidth-1:0] pc,
	input logic hlt,
	input logic wbValid,
	input logic [RegAddrWidth-1:0] wbReg,
	input logic [WordWidth-1:0] wbData
);

	// Nothing younger than HLT may write back
	property noWriteBackWhileHalted;
		@(posedge clk) disable iff (reset) hlt |-> !wbValid;
	endproperty

	// Halt latch only clears on reset
	property haltIsSticky;
		@(posedge clk) disable iff (reset) hlt |=> hlt;
	endproperty

	// Fetch frozen once halted
	property pcHeldWhileHalted;
		@(posedge clk) disable iff (reset) hlt |=> $stable(pc);
	endproperty

	// Low byte always defined
	// LLB into a never-written register leaves its high byte unknown
	property writeBackKnown;
		@(posedge clk) disable iff (reset)
			!$isunknown(wbValid) && (!wbValid || !$isunknown({wbReg, wbData[7:0]}));
	endproperty

	assert property (noWriteBackWhileHalted)
		else $error("write-back while hlt is high");
	assert property (haltIsSticky)
		else $error("hlt dropped without reset");
	assert property (pcHeldWhileHalted)
		else $error("pc moved while hlt is high");
	assert property (writeBackKnown)
		else $error("write-back with unknown register or data");

endmodule

bind cpu cpu_props propsCheck (.clk(clk), .reset(reset), .pc(pc), .hlt(hlt),
	.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

`default_nettype wire

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpuPkg::*; #(
	parameter int ProgAddrWidth = 8
) (
	input logic clk,
	input logic reset,
	// Program load port
	input logic progWrite,
	input logic [ProgAddrWidth-1:0] progAddr,
	input logic [WordWidth-1:0] progData,
	output logic [WordWidth-1:0] pc,
	output logic hlt,
	// Write-back observation
	output logic wbValid,
	output logic [RegAddrWidth-1:0] wbReg,
	output logic [WordWidth-1:0] wbData
);

	// Fetch to decode
	logic [WordWidth-1:0] instr;
	logic [WordWidth-1:0] instrPc;

	// Branch resolution and halt
	logic redirect;
	logic [WordWidth-1:0] redirectPc;
	logic squash;
	logic stop;

	// Write-back path, shared by register file and forwarding
	logic regWrite;
	logic [RegAddrWidth-1:0] writeReg;
	logic [WordWidth-1:0] writeData;

	decodeExecuteIf deIf ();
	executeResultIf erIf ();

	fetch #(.ProgAddrWidth(ProgAddrWidth)) fetchStage (.clk(clk), .reset(reset),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.redirect(redirect), .redirectPc(redirectPc), .stop(stop),
		.instr(instr), .instrPc(instrPc), .pc(pc));

	decode decodeStage (.clk(clk), .reset(reset), .instr(instr), .instrPc(instrPc),
		.squash(squash), .stop(stop), .regWrite(regWrite), .writeReg(writeReg),
		.writeData(writeData), .de(deIf.producer));

	execute executeStage (.clk(clk), .reset(reset), .de(deIf.consumer),
		.er(erIf.producer), .regWrite(regWrite), .writeReg(writeReg),
		.writeData(writeData), .redirect(redirect), .redirectPc(redirectPc),
		.squash(squash));

	result resultStage (.clk(clk), .reset(reset), .er(erIf.consumer),
		.regWrite(regWrite), .writeReg(writeReg), .writeData(writeData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .hlt(hlt));

endmodule

`default_nettype wire

// File: result.sv
`timescale 1ns/1ps
`default_nettype none

module result import cpuPkg::*; (
	input logic clk,
	input logic reset,
	executeResultIf.consumer er,
	// Register file write and forward source
	output logic regWrite,
	output logic [RegAddrWidth-1:0] writeReg,
	output logic [WordWidth-1:0] writeData,
	// Observation port
	output logic wbValid,
	output logic [RegAddrWidth-1:0] wbReg,
	output logic [WordWidth-1:0] wbData,
	output logic hlt
);

	logic rValid;
	logic rWritesReg;
	logic [RegAddrWidth-1:0] rRd;
	logic [WordWidth-1:0] rValue;

	// Execute/result register
	always_ff @(posedge clk) begin
		if (reset) begin
			rValid <= 1'b0;
			rWritesReg <= 1'b0;
		end else begin
			rValid <= er.valid;
			rWritesReg <= er.writesReg;
		end
	end

	always_ff @(posedge clk) begin
		rRd <= er.rd;
		rValue <= er.value;
	end

	// Halt latch, set as HLT enters this stage
	always_ff @(posedge clk) begin
		if (reset) begin
			hlt <= 1'b0;
		end else if (er.valid && er.isHalt) begin
			hlt <= 1'b1;
		end
	end

	// Only real register-writing instructions write back
	assign regWrite = rValid && rWritesReg;
	assign writeReg = rRd;
	assign writeData = rValue;

	assign wbValid = regWrite;
	assign wbReg = rRd;
	assign wbData = rValue;

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import cpuPkg::*; (
	input logic clk,
	input logic reset,
	decodeExecuteIf.consumer de,
	executeResultIf.producer er,
	// Result stage write, used as forward source
	input logic regWrite,
	input logic [RegAddrWidth-1:0] writeReg,
	input logic [WordWidth-1:0] writeData,
	output logic redirect,
	output logic [WordWidth-1:0] redirectPc,
	output logic squash
);

	localparam int Msb = WordWidth - 1;

	logic exValid;
	aluOpT exAluOp;
	logic exIsBranch;
	condT exCond;
	logic exWritesReg;
	logic exSetsFlags;
	logic exIsHalt;
	logic [RegAddrWidth-1:0] exRd;
	logic [RegAddrWidth-1:0] exRs;
	logic [RegAddrWidth-1:0] exRt;
	logic [WordWidth-1:0] exOpA;
	logic [WordWidth-1:0] exOpB;
	logic [WordWidth-1:0] exImm;
	logic [WordWidth-1:0] exTarget;
	logic [WordWidth-1:0] srcA;
	logic [WordWidth-1:0] srcB;
	logic [WordWidth-1:0] aluOut;
	logic overflow;
	logic condTrue;
	flagsT flags;

	// Decode/execute register, a taken branch bubbles its successor
	always_ff @(posedge clk) begin
		if (reset || squash) begin
			exValid <= 1'b0;
		end else begin
			exValid <= de.valid;
		end
	end

	always_ff @(posedge clk) begin
		exAluOp <= de.aluOp;
		exIsBranch <= de.isBranch;
		exCond <= de.cond;
		exWritesReg <= de.writesReg;
		exSetsFlags <= de.setsFlags;
		exIsHalt <= de.isHalt;
		exRd <= de.rd;
		exRs <= de.rs;
		exRt <= de.rt;
		exOpA <= de.opA;
		exOpB <= de.opB;
		exImm <= de.imm;
		exTarget <= de.branchTarget;
	end

	// Forward from the instruction now writing back
	assign srcA = (regWrite && (writeReg == exRs)) ? writeData : exOpA;
	assign srcB = (regWrite && (writeReg == exRt)) ? writeData : exOpB;

	// ALU
	always_comb begin
		overflow = 1'b0;
		case (exAluOp)
			AluAdd: begin
				aluOut = srcA + srcB;
				overflow = (srcA[Msb] == srcB[Msb]) && (aluOut[Msb] != srcA[Msb]);
			end
			AluSub: begin
				aluOut = srcA - srcB;
				overflow = (srcA[Msb] != srcB[Msb]) && (aluOut[Msb] != srcA[Msb]);
			end
			AluXor: aluOut = srcA ^ srcB;
			// Old rd on srcA keeps the other byte
			AluLowByte: aluOut = {srcA[15:8], exImm[7:0]};
			AluHighByte: aluOut = {exImm[15:8], srcA[7:0]};
			default: aluOut = srcA;
		endcase
	end

	// Flags, XOR clears V via overflow staying low
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (exValid && exSetsFlags) begin
			flags.n <= aluOut[Msb];
			flags.v <= overflow;
			flags.z <= (aluOut == '0);
		end
	end

	// Condition on the flags left by older instructions
	always_comb begin
		case (exCond)
			CondNe: condTrue = !flags.z;
			CondEq: condTrue = flags.z;
			CondGt: condTrue = !flags.z && !flags.n;
			CondLt: condTrue = flags.n;
			CondGe: condTrue = !flags.n;
			CondLe: condTrue = flags.n || flags.z;
			CondOv: condTrue = flags.v;
			CondAlways: condTrue = 1'b1;
		endcase
	end

	// One-cycle pulse, kills decode and fetch contents
	assign redirect = exValid && exIsBranch && condTrue;
	assign redirectPc = exTarget;
	assign squash = redirect;

	assign er.valid = exValid;
	assign er.rd = exRd;
	assign er.writesReg = exWritesReg;
	assign er.isHalt = exIsHalt;
	assign er.value = aluOut;

endmodule

`default_nettype wire

// File: decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import cpuPkg::*; (
	input logic clk,
	input logic reset,
	input logic [WordWidth-1:0] instr,
	input logic [WordWidth-1:0] instrPc,
	input logic squash,
	output logic stop,
	// Write port from the result stage
	input logic regWrite,
	input logic [RegAddrWidth-1:0] writeReg,
	input logic [WordWidth-1:0] writeData,
	decodeExecuteIf.producer de
);

	logic decValid;
	logic [WordWidth-1:0] decInstr;
	logic [WordWidth-1:0] decPc;
	logic haltSeen;
	logic haltNow;
	logic isByteLoad;
	opcodeT opcode;
	logic [RegAddrWidth-1:0] rsSel;
	logic [RegAddrWidth-1:0] rtSel;
	logic [WordWidth-1:0] regFile [2**RegAddrWidth];

	// Fetch/decode register
	// Squash drops the word just fetched, stop inserts bubbles
	always_ff @(posedge clk) begin
		if (reset || squash) begin
			decValid <= 1'b0;
		end else begin
			decValid <= !stop;
		end
	end

	always_ff @(posedge clk) begin
		decInstr <= instr;
		decPc <= instrPc;
	end

	// Sticky halt, holds the pc from here on
	assign haltNow = decValid && !squash && (opcode == OpHalt);

	always_ff @(posedge clk) begin
		if (reset) begin
			haltSeen <= 1'b0;
		end else if (haltNow) begin
			haltSeen <= 1'b1;
		end
	end

	assign stop = haltSeen || haltNow;

	// Register file write
	always_ff @(posedge clk) begin
		if (regWrite) begin
			regFile[writeReg] <= writeData;
		end
	end

	assign opcode = opcodeT'(decInstr[15:12]);
	assign isByteLoad = (opcode == OpLlb) || (opcode == OpLhb);

	// LLB/LHB read their own rd, the untouched byte comes from it
	assign rsSel = isByteLoad ? decInstr[11:8] : decInstr[7:4];
	assign rtSel = decInstr[3:0];

	// Reads with write-through on a same-cycle write
	assign de.opA = (regWrite && (writeReg == rsSel)) ? writeData : regFile[rsSel];
	assign de.opB = (regWrite && (writeReg == rtSel)) ? writeData : regFile[rtSel];

	// Control decode
	always_comb begin
		de.aluOp = AluPass;
		de.writesReg = 1'b0;
		de.setsFlags = 1'b0;
		case (opcode)
			OpAdd: begin
				de.aluOp = AluAdd;
				de.writesReg = 1'b1;
				de.setsFlags = 1'b1;
			end
			OpSub: begin
				de.aluOp = AluSub;
				de.writesReg = 1'b1;
				de.setsFlags = 1'b1;
			end
			OpXor: begin
				de.aluOp = AluXor;
				de.writesReg = 1'b1;
				de.setsFlags = 1'b1;
			end
			OpLlb: begin
				de.aluOp = AluLowByte;
				de.writesReg = 1'b1;
			end
			OpLhb: begin
				de.aluOp = AluHighByte;
				de.writesReg = 1'b1;
			end
			default: begin
				de.aluOp = AluPass;
			end
		endcase
	end

	assign de.valid = decValid;
	assign de.isBranch = (opcode == OpBranch);
	assign de.isHalt = (opcode == OpHalt);
	assign de.cond = condT'(decInstr[11:9]);
	assign de.rd = decInstr[11:8];
	assign de.rs = rsSel;
	assign de.rt = rtSel;

	// Byte sits in the lane it will land in
	assign de.imm = (opcode == OpLhb) ? {decInstr[7:0], 8'h00} : {8'h00, decInstr[7:0]};

	// pc + 1 + sign-extended 9-bit offset
	assign de.branchTarget = decPc + 1'b1 + {{(WordWidth-9){decInstr[8]}}, decInstr[8:0]};

endmodule

`default_nettype wire

// File: fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch import cpuPkg::*; #(
	parameter int ProgAddrWidth = 8
) (
	input logic clk,
	input logic reset,
	// Program load port, used while the core is in reset
	input logic progWrite,
	input logic [ProgAddrWidth-1:0] progAddr,
	input logic [WordWidth-1:0] progData,
	// Taken branch from execute
	input logic redirect,
	input logic [WordWidth-1:0] redirectPc,
	// Halt decoded
	input logic stop,
	output logic [WordWidth-1:0] instr,
	output logic [WordWidth-1:0] instrPc,
	output logic [WordWidth-1:0] pc
);

	// Program memory, 2**ProgAddrWidth words
	logic [WordWidth-1:0] progMem [2**ProgAddrWidth];
	logic [WordWidth-1:0] pcReg;

	// Load port write
	always_ff @(posedge clk) begin
		if (progWrite) begin
			progMem[progAddr] <= progData;
		end
	end

	// Program counter
	// Redirect beats stop, a branch older than HLT still wins
	always_ff @(posedge clk) begin
		if (reset) begin
			pcReg <= '0;
		end else if (redirect) begin
			pcReg <= redirectPc;
		end else if (!stop) begin
			pcReg <= pcReg + 1'b1;
		end
	end

	// Asynchronous read, upper pc bits wrap
	assign instr = progMem[pcReg[ProgAddrWidth-1:0]];

	// Same pc goes down the pipe with the word
	assign instrPc = pcReg;

	// Observation copy for the top level
	assign pc = pcReg;

endmodule

`default_nettype wire

// File: cpuIfs.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction bundle, decode to execute
interface decodeExecuteIf import cpuPkg::*; ();
	logic valid;
	aluOpT aluOp;
	logic isBranch;
	condT cond;
	logic writesReg;
	logic setsFlags;
	logic isHalt;
	logic [RegAddrWidth-1:0] rd;
	logic [RegAddrWidth-1:0] rs;
	logic [RegAddrWidth-1:0] rt;
	// Register file reads, already bypassed
	logic [WordWidth-1:0] opA;
	logic [WordWidth-1:0] opB;
	// Byte immediate placed in its final lane
	logic [WordWidth-1:0] imm;
	logic [WordWidth-1:0] branchTarget;

	modport producer (output valid, aluOp, isBranch, cond, writesReg, setsFlags,
		isHalt, rd, rs, rt, opA, opB, imm, branchTarget);
	modport consumer (input valid, aluOp, isBranch, cond, writesReg, setsFlags,
		isHalt, rd, rs, rt, opA, opB, imm, branchTarget);
endinterface

// Execute result bundle, execute to result
interface executeResultIf import cpuPkg::*; ();
	logic valid;
	logic [RegAddrWidth-1:0] rd;
	logic writesReg;
	logic isHalt;
	logic [WordWidth-1:0] value;

	modport producer (output valid, rd, writesReg, isHalt, value);
	modport consumer (input valid, rd, writesReg, isHalt, value);
endinterface

`default_nettype wire

// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Data, instruction and register index widths
	localparam int WordWidth = 16;
	localparam int RegAddrWidth = 4;

	// Opcode field, instr[15:12]
	// Codes not listed here behave as no-ops
	typedef enum logic [3:0] {
		OpAdd = 4'd0,
		OpSub = 4'd1,
		OpXor = 4'd2,
		OpLlb = 4'd10,
		OpLhb = 4'd11,
		OpBranch = 4'd12,
		OpHalt = 4'd15
	} opcodeT;

	// Branch condition field, instr[11:9]
	typedef enum logic [2:0] {
		CondNe,
		CondEq,
		CondGt,
		CondLt,
		CondGe,
		CondLe,
		CondOv,
		CondAlways
	} condT;

	// Flag register layout
	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flagsT;

	// Operation chosen in decode, carried out in execute
	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluXor,
		AluLowByte,
		AluHighByte,
		AluPass
	} aluOpT;

endpackage

`default_nettype wire
